// File: verilog.f
+incdir+testbench
logic/zx81_pkg.sv
logic/zx_bus_if.sv
logic/bus_handshake.sv
logic/ram_mapper.sv
logic/io_port_decoder.sv
logic/zxpand_joy.sv
logic/zx81_port_top.sv
testbench/tb_zx81_port.sv

// File: run.sh
#!/bin/sh
# Build the ZX81 port testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f verilog.f --top-module tb_zx81_port -o tb_zx81_port

out=$(./obj_dir/tb_zx81_port)
echo "$out"

if echo "$out" | grep -qx "Everything OK"; then
	exit 0
fi
exit 1

// File: testbench/tb_ref_model.svh
/*
 Reference model for the ZX81 port testbench
 Expected RAM mapping, joystick key mask, ZXpand byte and I/O read byte
*/
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam logic [15:0] ZXPAND_ADDR = 16'hE007;
localparam logic [15:0] CHROMA_ADDR = 16'h7FEF;
localparam logic [7:0]  IDLE_READ   = 8'hFF;
localparam logic [7:0]  CHROMA_ID   = 8'hDF;

// One expected response
typedef struct packed {
	logic [7:0]  rdata;
	logic        chk_rdata; // Write data byte is not compared
	logic        ram_hit;
	logic [15:0] ram_addr;
} rsp_t;

function automatic logic ram_hit_of(input logic [15:0] addr, input logic [1:0] size,
		input logic low_en, input logic m1);
	logic high_ram;
	logic low_ram;
	high_ram = addr[15] && size >= 2'd2 && (!addr[14] || (!m1 && size == 2'd3));
	low_ram  = low_en && addr >= 16'h2000 && addr <= 16'h3FFF;
	ram_hit_of = addr[14] || high_ram || low_ram;
endfunction

function automatic logic [15:0] ram_addr_of(input logic [15:0] addr, input logic [1:0] size,
		input logic low_en, input logic m1);
	logic [1:0]  bank;
	logic [15:0] offset;
	bank   = addr[15:14];
	offset = {2'b00, addr[13:0]};
	if (low_en && addr >= 16'h2000 && addr <= 16'h3FFF) begin
		ram_addr_of = 16'h2000 + {3'b000, addr[12:0]};
	end else if (size == 2'd0) begin
		ram_addr_of = 16'h4000 + {6'b000000, addr[9:0]}; // 1K mirrored
	end else if (size == 2'd1 || !bank[1] || (bank == 2'd3 && size == 2'd2)) begin
		ram_addr_of = 16'h4000 + offset;
	end else if (bank == 2'd2) begin
		ram_addr_of = 16'h8000 + offset;
	end else if (m1) begin
		ram_addr_of = 16'h4000 + offset; // Opcode fetch mirror at 48K
	end else begin
		ram_addr_of = 16'hC000 + offset;
	end
endfunction

// Active low column mask from the joystick
function automatic logic [4:0] joy_mask_of(input logic [15:0] addr, input logic [1:0] layout,
		input logic [4:0] js);
	logic       right;
	logic       left;
	logic       down;
	logic       up;
	logic       fire;
	logic [4:0] row12;
	logic [4:0] row11;
	right = js[0];
	left  = js[1];
	down  = js[2];
	up    = js[3];
	fire  = js[4];
	row12 = 5'b00000;
	row11 = 5'b00000;
	if (layout == 2'd0) begin
		row12 = {down, up, right, 1'b0, fire};
		row11 = {left, 4'b0000};
	end
	if (layout == 2'd1 || layout == 2'd3)
		row12 = row12 | {left, right, down, up, fire};
	if (layout == 2'd2 || layout == 2'd3)
		row12 = row12 | {down, up, right, left, fire};
	if (addr[12])
		row12 = 5'b00000; // Row not selected
	if (addr[11])
		row11 = 5'b00000;
	joy_mask_of = ~(row12 | row11);
endfunction

function automatic logic [7:0] zxp_byte_after(input logic [7:0] wdata, input logic [4:0] js);
	case (wdata)
		8'hAA:   zxp_byte_after = 8'hF0;
		8'h55:   zxp_byte_after = 8'h0F;
		8'hA0:   zxp_byte_after = {~js[3], ~js[2], ~js[1], ~js[0], ~js[4], 3'b000};
		default: zxp_byte_after = 8'hFF;
	endcase
endfunction

function automatic logic [7:0] io_byte_of(input logic [15:0] addr, input logic [4:0] keys,
		input logic hz, input logic [4:0] mask, input logic [7:0] zxp, input logic chroma_on);
	if (!addr[0])
		io_byte_of = {1'b0, hz, 1'b0, keys & mask};
	else if (addr == ZXPAND_ADDR)
		io_byte_of = zxp;
	else if (chroma_on && addr == CHROMA_ADDR)
		io_byte_of = CHROMA_ID;
	else
		io_byte_of = IDLE_READ;
endfunction

`endif

// File: testbench/tb_zx81_port.sv
/*
 ZX81 port testbench
 Random bus requests against the reference model, with a random
 response stall, per test report and a watchdog
*/
module tb_zx81_port;
	timeunit 1ns;
	timeprecision 100ps;

	`include "tb_ref_model.svh"

	localparam int          CLK_PERIOD   = 10;
	localparam int          RESET_CYCLES = 8;
	localparam logic [7:0]  ZXP_IDLE     = 8'hE5;
	localparam int N_MEM = 400;
	localparam int N_HS  = 300;
	localparam int N_KBD = 200;
	localparam int N_JOY = 200;
	localparam int N_ZXP_RAND = 40;
	localparam int N_ZXP = 7 + 2 * N_ZXP_RAND + 30;
	localparam int N_CHR = 2 * 60;
	localparam int TOTAL_REQ   = N_MEM + N_HS + N_KBD + N_JOY + N_ZXP + N_CHR;
	localparam int WATCHDOG_NS = (TOTAL_REQ * 20 + RESET_CYCLES) * CLK_PERIOD;

	logic        clk_sys;
	logic        reset;
	logic        req_valid, req_ready, req_io, req_write, req_m1;
	logic [15:0] req_addr;
	logic [7:0]  req_wdata;
	logic        rsp_valid, rsp_ready, rsp_ram_hit;
	logic [7:0]  rsp_rdata;
	logic [15:0] rsp_ram_addr;
	logic [1:0]  mem_size, joy_layout;
	logic        low_ram_en, chroma_en, hz50;
	logic [4:0]  joystick, key_cols;
	logic [7:0]  chroma_reg;

	// Model state
	rsp_t       rsp_queue[$];
	logic       exp_valid;
	logic [7:0] exp_zxp;
	logic       exp_use;
	logic [7:0] exp_chroma;
	logic       fired;
	int seed = 32'h7ba8_d657;
	int stall_pct = 0;
	int errors = 0;
	int requests = 0;
	int responses = 0;
	int err_base, req_base;

	zx81_port_top #(
		.ZXP_IDLE (ZXP_IDLE)
	) i_zx81_port_top (
		.clk_sys (clk_sys), .reset (reset),
		.req_valid (req_valid), .req_ready (req_ready), .req_addr (req_addr),
		.req_wdata (req_wdata), .req_io (req_io), .req_write (req_write), .req_m1 (req_m1),
		.rsp_valid (rsp_valid), .rsp_ready (rsp_ready), .rsp_rdata (rsp_rdata),
		.rsp_ram_hit (rsp_ram_hit), .rsp_ram_addr (rsp_ram_addr),
		.mem_size (mem_size), .low_ram_en (low_ram_en), .chroma_en (chroma_en),
		.joy_layout (joy_layout), .joystick (joystick), .key_cols (key_cols),
		.hz50 (hz50), .chroma_reg (chroma_reg)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns with the run still going", WATCHDOG_NS);
		$display("Something failed");
		$finish;
	end

	task automatic flag_mismatch(input string name, input logic [15:0] got, input logic [15:0] exp);
		$display("error %s: got %h, expected %h", name, got, exp);
		errors++;
	endtask

	// ========================================
	// One clock of checks, model update and drive
	// ========================================

	task automatic clock_cycle();
		rsp_t        head;
		rsp_t        next_rsp;
		logic [4:0]  mask;
		logic [31:0] r;
		@(negedge clk_sys); // Values the coming rising edge will see
		fired = req_valid && req_ready;
		if (req_ready !== (!exp_valid || rsp_ready))
			flag_mismatch("req_ready", 16'(req_ready), 16'(!exp_valid || rsp_ready));
		if (rsp_valid !== exp_valid)
			flag_mismatch("rsp_valid", 16'(rsp_valid), 16'(exp_valid));
		if (chroma_reg !== exp_chroma)
			flag_mismatch("chroma_reg", 16'(chroma_reg), 16'(exp_chroma));
		// Held response compared every cycle, so a stall must keep it stable
		if (rsp_valid && rsp_queue.size() == 0) begin
			$display("Response seen with no request outstanding");
			errors++;
		end else if (rsp_valid) begin
			head = rsp_queue[0];
			if (head.chk_rdata && rsp_rdata !== head.rdata)
				flag_mismatch("rsp_rdata", 16'(rsp_rdata), 16'(head.rdata));
			if (rsp_ram_hit !== head.ram_hit)
				flag_mismatch("rsp_ram_hit", 16'(rsp_ram_hit), 16'(head.ram_hit));
			if (rsp_ram_addr !== head.ram_addr)
				flag_mismatch("rsp_ram_addr", rsp_ram_addr, head.ram_addr);
			if (rsp_ready) begin
				void'(rsp_queue.pop_front());
				responses++;
			end
		end
		if (fired) begin
			mask = exp_use ? 5'h1F : joy_mask_of(req_addr, joy_layout, joystick);
			next_rsp.chk_rdata = !(req_io && req_write);
			next_rsp.rdata     = IDLE_READ;
			next_rsp.ram_hit   = 1'b0;
			next_rsp.ram_addr  = 16'h0000;
			if (req_io) begin
				next_rsp.rdata = io_byte_of(req_addr, key_cols, hz50, mask, exp_zxp, chroma_en);
			end else begin
				next_rsp.ram_hit  = ram_hit_of(req_addr, mem_size, low_ram_en, req_m1);
				next_rsp.ram_addr = ram_addr_of(req_addr, mem_size, low_ram_en, req_m1);
			end
			rsp_queue.push_back(next_rsp);
			if (req_io && req_write && req_addr == ZXPAND_ADDR) begin
				exp_zxp = zxp_byte_after(req_wdata, joystick);
				exp_use = exp_use || (req_wdata == 8'hA0);
			end
		end
		if (!chroma_en)
			exp_chroma = 8'h00;
		else if (fired && req_io && req_write && req_addr == CHROMA_ADDR)
			exp_chroma = req_wdata;
		if (fired)
			exp_valid = 1'b1;
		else if (rsp_ready)
			exp_valid = 1'b0;
		@(posedge clk_sys);
		#1;
		r = $random(seed);
		rsp_ready = (r % 100) >= stall_pct;
	endtask

	task automatic issue_request(input logic [15:0] addr, input logic [7:0] wdata,
			input logic io, input logic write, input logic m1);
		req_valid = 1'b1;
		req_addr  = addr;
		req_wdata = wdata;
		req_io    = io;
		req_write = write;
		req_m1    = m1;
		fired     = 1'b0;
		while (!fired)
			clock_cycle();
		req_valid = 1'b0;
		requests++;
	endtask

	task automatic write_then_read(input logic [15:0] addr, input logic [7:0] value);
		issue_request(addr, value, 1'b1, 1'b1, 1'b0);
		issue_request(addr, 8'h00, 1'b1, 1'b0, 1'b0);
	endtask

	task automatic drain_responses();
		int n;
		n = 0;
		stall_pct = 0;
		while (rsp_queue.size() != 0 && n < 50) begin
			clock_cycle();
			n++;
		end
		if (rsp_queue.size() != 0) begin
			$display("%0d accepted requests never got a response", rsp_queue.size());
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		$display("%s: %0d requests, %0d errors", name, requests - req_base, errors - err_base);
		req_base = requests;
		err_base = errors;
	endtask

	// ========================================
	// Tests
	// ========================================

	task automatic memory_map_test();
		logic [31:0] r;
		for (int i = 0; i < N_MEM; i++) begin
			r = $random(seed);
			mem_size   = r[1:0];
			low_ram_en = r[2];
			issue_request(r[31:16], r[15:8], 1'b0, r[3], r[4]);
		end
		drain_responses();
		report_test("memory map");
	endtask

	task automatic handshake_test();
		logic [31:0] r;
		stall_pct = 50;
		for (int i = 0; i < N_HS; i++) begin
			r = $random(seed);
			mem_size   = r[1:0];
			low_ram_en = r[2];
			if (r[6:5] == 2'd0)
				clock_cycle(); // Idle gap
			issue_request(r[31:16], 8'h00, r[3], 1'b0, r[4]);
		end
		drain_responses();
		report_test("handshake");
	endtask

	task automatic keyboard_test(input string name, input int count, input logic full_cols);
		logic [31:0] r;
		for (int i = 0; i < count; i++) begin
			r = $random(seed);
			key_cols   = full_cols ? 5'h1F : r[4:0];
			hz50       = r[5];
			joystick   = r[10:6];
			joy_layout = r[12:11];
			issue_request({r[31:17], 1'b0}, 8'h00, 1'b1, 1'b0, 1'b0);
		end
		drain_responses();
		report_test(name);
	endtask

	task automatic zxpand_test();
		logic [31:0] r;
		issue_request(ZXPAND_ADDR, 8'h00, 1'b1, 1'b0, 1'b0); // Value after reset
		write_then_read(ZXPAND_ADDR, 8'hAA);
		write_then_read(ZXPAND_ADDR, 8'h55);
		for (int i = 0; i < N_ZXP_RAND; i++) begin
			r = $random(seed);
			joystick = r[12:8];
			write_then_read(ZXPAND_ADDR, r[7:0]);
		end
		r = $random(seed);
		joystick = r[4:0];
		write_then_read(ZXPAND_ADDR, 8'hA0);
		drain_responses();
		keyboard_test("zxpand", 30, 1'b0); // Joystick now leaves the keys alone
	endtask

	task automatic chroma_test();
		logic [31:0] r;
		for (int i = 0; i < N_CHR / 2; i++) begin
			r = $random(seed);
			chroma_en = (r[9:8] != 2'd0);
			write_then_read(CHROMA_ADDR, r[7:0]);
		end
		drain_responses();
		report_test("chroma81");
	endtask

	initial begin
		reset = 1'b1;
		req_valid = 1'b0;
		req_addr = 16'h0000;
		req_wdata = 8'h00;
		req_io = 1'b0;
		req_write = 1'b0;
		req_m1 = 1'b0;
		rsp_ready = 1'b1;
		mem_size = 2'd0;
		low_ram_en = 1'b0;
		chroma_en = 1'b0;
		joy_layout = 2'd0;
		joystick = 5'h00;
		key_cols = 5'h1F;
		hz50 = 1'b0;
		exp_valid = 1'b0;
		exp_zxp = ZXP_IDLE;
		exp_use = 1'b0;
		exp_chroma = 8'h00;
		err_base = 0;
		req_base = 0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		memory_map_test();
		handshake_test();
		keyboard_test("keyboard", N_KBD, 1'b0);
		keyboard_test("joystick", N_JOY, 1'b1);
		zxpand_test();
		chroma_test();

		$display("Responses checked %0d, errors %0d", responses, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: logic/zx81_port_top.sv
/*
 ZX81 bus port top level
 Takes Z80 bus requests on a valid/ready handshake and answers each with
 the RAM mapping or the I/O read byte
*/
module zx81_port_top #(
	parameter logic [7:0] ZXP_IDLE = 8'hFF
) (
	input  logic                    clk_sys,
	input  logic                    reset,

	// Request
	input  logic                    req_valid,
	output logic                    req_ready,
	input  logic [15:0]             req_addr,
	input  logic [7:0]              req_wdata,
	input  logic                    req_io,
	input  logic                    req_write,
	input  logic                    req_m1,

	// Response
	output logic                    rsp_valid,
	input  logic                    rsp_ready,
	output logic [7:0]              rsp_rdata,
	output logic                    rsp_ram_hit,
	output logic [15:0]             rsp_ram_addr,

	// Hardware settings
	input  zx81_pkg::mem_size_t     mem_size,
	input  logic                    low_ram_en,
	input  logic                    chroma_en,
	input  zx81_pkg::joy_layout_t   joy_layout,

	input  logic [4:0]              joystick,  // Fire up down left right
	input  logic [4:0]              key_cols,  // Active low columns
	input  logic                    hz50,
	output logic [7:0]              chroma_reg
);

	logic        ram_hit;
	logic [15:0] ram_addr;
	logic [7:0]  io_rdata;
	logic [4:0]  joy_cols;
	logic [7:0]  zxp_byte;

	zx_bus_if bus_if ();

	bus_handshake i_bus_handshake (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.req_valid    (req_valid),
		.req_ready    (req_ready),
		.req_addr     (req_addr),
		.req_wdata    (req_wdata),
		.req_io       (req_io),
		.req_write    (req_write),
		.req_m1       (req_m1),
		.rsp_valid    (rsp_valid),
		.rsp_ready    (rsp_ready),
		.rsp_rdata    (rsp_rdata),
		.rsp_ram_hit  (rsp_ram_hit),
		.rsp_ram_addr (rsp_ram_addr),
		.bus          (bus_if),
		.ram_hit      (ram_hit),
		.ram_addr     (ram_addr),
		.io_rdata     (io_rdata)
	);

	ram_mapper i_ram_mapper (
		.bus        (bus_if),
		.mem_size   (mem_size),
		.low_ram_en (low_ram_en),
		.ram_hit    (ram_hit),
		.ram_addr   (ram_addr)
	);

	io_port_decoder i_io_port_decoder (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.bus        (bus_if),
		.chroma_en  (chroma_en),
		.key_cols   (key_cols),
		.hz50       (hz50),
		.joy_cols   (joy_cols),
		.zxp_byte   (zxp_byte),
		.io_rdata   (io_rdata),
		.chroma_reg (chroma_reg)
	);

	zxpand_joy #(
		.ZXP_IDLE (ZXP_IDLE)
	) i_zxpand_joy (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.bus        (bus_if),
		.joy_layout (joy_layout),
		.joystick   (joystick),
		.joy_cols   (joy_cols),
		.zxp_byte   (zxp_byte)
	);

endmodule

// File: logic/zxpand_joy.sv
/*
 ZXpand port and joystick mapping
 Holds the ZXpand response byte and folds the joystick onto
 keyboard columns for the selected layouts
*/
module zxpand_joy #(
	parameter logic [7:0] ZXP_IDLE = 8'hFF
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	zx_bus_if.sink                bus,
	input  zx81_pkg::joy_layout_t joy_layout,
	input  logic [4:0]            joystick,  // Fire up down left right
	output logic [4:0]            joy_cols,
	output logic [7:0]            zxp_byte
);

	logic       zxp_use;   // Joystick handed to ZXpand
	logic       zxp_wr;
	logic       cursor;
	logic       sinclair;
	logic       zx81;
	logic [4:0] keys_row4; // Keys on row select A12
	logic [4:0] keys_row3; // Keys on row select A11

	// ========================================
	// ZXpand port
	// ========================================

	assign zxp_wr = bus.fire & bus.io & bus.write & (bus.addr == zx81_pkg::ZXPAND_PORT);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			zxp_use  <= 1'b0;
			zxp_byte <= ZXP_IDLE;
		end else if (zxp_wr) begin
			case (bus.wdata)
				8'hAA: zxp_byte <= 8'hF0;
				8'h55: zxp_byte <= 8'h0F;
				8'hA0: begin
					zxp_use  <= 1'b1;
					zxp_byte <= {~joystick[3:0], ~joystick[4], 3'b000}; // Active low snapshot
				end
				default: zxp_byte <= 8'hFF;
			endcase
		end
	end

	// ========================================
	// Joystick to keyboard
	// ========================================

	assign cursor   = (joy_layout == zx81_pkg::JOY_CURSOR);
	assign sinclair = (joy_layout == zx81_pkg::JOY_SINCLAIR) | (joy_layout == zx81_pkg::JOY_BOTH);
	assign zx81     = (joy_layout == zx81_pkg::JOY_ZX81) | (joy_layout == zx81_pkg::JOY_BOTH);

	assign keys_row4 =
		({5{sinclair}} & {joystick[1], joystick[0], joystick[2], joystick[3], joystick[4]}) |
		({5{zx81}} & {joystick[2], joystick[3], joystick[0], joystick[1], joystick[4]}) |
		({5{cursor}} & {joystick[2], joystick[3], joystick[0], 1'b0, joystick[4]});

	assign keys_row3 = {5{cursor}} & {joystick[1], 4'b0000}; // Cursor left is key 5

	// A set row select bit masks that row out
	assign joy_cols = {5{zxp_use}} |
		(({5{bus.addr.io.row[4]}} | ~keys_row4) & ({5{bus.addr.io.row[3]}} | ~keys_row3));

endmodule

// File: logic/io_port_decoder.sv
/*
 I/O read decoder and Chroma81 control
 Builds the byte for keyboard, ZXpand and Chroma81 reads and holds
 the Chroma81 mode register
*/
module io_port_decoder (
	input  logic       clk_sys,
	input  logic       reset,
	zx_bus_if.sink     bus,
	input  logic       chroma_en,
	input  logic [4:0] key_cols,  // Active low
	input  logic       hz50,
	input  logic [4:0] joy_cols,  // Joystick mask, active low
	input  logic [7:0] zxp_byte,
	output logic [7:0] io_rdata,
	output logic [7:0] chroma_reg
);

	logic kbd_sel;
	logic zxp_sel;
	logic chroma_sel;
	logic chroma_wr;

	// ========================================
	// Port selects
	// ========================================

	// Any even port read is the keyboard
	assign kbd_sel    = bus.io & ~bus.write & ~bus.addr.io.port[0];
	assign zxp_sel    = bus.io & (bus.addr == zx81_pkg::ZXPAND_PORT);
	assign chroma_sel = bus.io & chroma_en & (bus.addr == zx81_pkg::CHROMA_PORT);
	assign chroma_wr  = bus.fire & bus.write & chroma_sel;

	// ========================================
	// Read byte
	// ========================================

	always_comb begin
		if (kbd_sel) begin
			io_rdata = {1'b0, hz50, 1'b0, key_cols & joy_cols}; // Tape in reads 0
		end else if (zxp_sel) begin
			io_rdata = zxp_byte;
		end else if (chroma_sel) begin
			io_rdata = zx81_pkg::CHROMA_READ;
		end else begin
			io_rdata = zx81_pkg::IDLE_BYTE;
		end
	end

	// ========================================
	// Chroma81 register
	// ========================================

	// Cleared and held while Chroma81 is off
	always_ff @(posedge clk_sys) begin
		if (reset | ~chroma_en) begin
			chroma_reg <= 8'h00;
		end else if (chroma_wr) begin
			chroma_reg <= bus.wdata;
		end
	end

endmodule

// File: logic/ram_mapper.sv
/*
 Memory map decoder
 Maps a memory cycle onto the 64K RAM space for 1K to 48K main RAM,
 the optional 8K low RAM and the 48K opcode fetch mirror
*/
module ram_mapper (
	zx_bus_if.sink              bus,
	input  zx81_pkg::mem_size_t mem_size,
	input  logic                low_ram_en,
	output logic                ram_hit,
	output logic [15:0]         ram_addr
);

	logic [1:0]  bank;
	logic [13:0] offset;
	logic        big_mem;  // 32K or 48K
	logic        lo_sel;
	logic        hi_sel;

	assign bank    = bus.addr.mem.bank;
	assign offset  = bus.addr.mem.offset;
	assign big_mem = (mem_size == zx81_pkg::MEM_32K) | (mem_size == zx81_pkg::MEM_48K);

	// 8K at 2000h-3FFFh
	assign lo_sel = low_ram_en & (bank == 2'd0) & offset[13];

	// Upper half with bank 3 only on data cycles at 48K
	assign hi_sel = bank[1] & big_mem &
		(~bank[0] | (~bus.m1 & (mem_size == zx81_pkg::MEM_48K)));

	assign ram_hit = bank[0] | hi_sel | lo_sel;

	// ========================================
	// RAM address
	// ========================================

	always_comb begin
		ram_addr = {2'b01, offset};
		if (lo_sel) begin
			ram_addr = {3'b001, offset[12:0]};
		end else begin
			case (mem_size)
				zx81_pkg::MEM_1K: ram_addr = {6'b010000, offset[9:0]}; // Mirrored 1K
				zx81_pkg::MEM_16K: ram_addr = {2'b01, offset};
				zx81_pkg::MEM_32K: begin
					if (bank == 2'd2) begin
						ram_addr = {2'b10, offset};
					end else begin
						ram_addr = {2'b01, offset}; // Bank 3 mirrors main 16K
					end
				end
				zx81_pkg::MEM_48K: begin
					case (bank)
						2'd2:    ram_addr = {2'b10, offset};
						2'd3:    ram_addr = {~bus.m1, 1'b1, offset}; // M1 sees main 16K
						default: ram_addr = {2'b01, offset};
					endcase
				end
			endcase
		end
	end

endmodule

// File: logic/bus_handshake.sv
/*
 Bus request handshake
 Accepts one request per cycle into a one-deep response register,
 answering exactly one cycle after acceptance
*/
module bus_handshake (
	input  logic        clk_sys,
	input  logic        reset,

	input  logic        req_valid,
	output logic        req_ready,
	input  logic [15:0] req_addr,
	input  logic [7:0]  req_wdata,
	input  logic        req_io,
	input  logic        req_write,
	input  logic        req_m1,

	output logic        rsp_valid,
	input  logic        rsp_ready,
	output logic [7:0]  rsp_rdata,
	output logic        rsp_ram_hit,
	output logic [15:0] rsp_ram_addr,

	zx_bus_if.source    bus,

	// Decoder results for the cycle on the bus
	input  logic        ram_hit,
	input  logic [15:0] ram_addr,
	input  logic [7:0]  io_rdata
);

	logic fire;

	// ========================================
	// Acceptance
	// ========================================

	// Room when empty or when the held response leaves this cycle
	assign req_ready = ~rsp_valid | rsp_ready;
	assign fire      = req_valid & req_ready;

	assign bus.fire  = fire;
	assign bus.addr  = req_addr;
	assign bus.wdata = req_wdata;
	assign bus.io    = req_io;
	assign bus.write = req_write;
	assign bus.m1    = req_m1;

	// ========================================
	// Response register
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rsp_valid <= 1'b0;
		end else if (fire) begin
			rsp_valid <= 1'b1; // Refilled, or overwritten as it drains
		end else if (rsp_ready) begin
			rsp_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (fire) begin
			if (req_io) begin
				rsp_rdata    <= io_rdata;
				rsp_ram_hit  <= 1'b0;
				rsp_ram_addr <= 16'h0000;
			end else begin
				rsp_rdata    <= zx81_pkg::IDLE_BYTE; // Memory data comes from RAM
				rsp_ram_hit  <= ram_hit;
				rsp_ram_addr <= ram_addr;
			end
		end
	end

endmodule

// File: logic/zx_bus_if.sv
/*
 Accepted bus cycle
 One request as seen by the decoders, valid on the fire strobe
*/
interface zx_bus_if;

	logic               fire;  // Request accepted this cycle
	zx81_pkg::zx_addr_t addr;
	logic [7:0]         wdata;
	logic               io;    // I/O cycle, else memory
	logic               write;
	logic               m1;    // Opcode fetch

	modport source (
		output fire,
		output addr,
		output wdata,
		output io,
		output write,
		output m1
	);

	modport sink (
		input fire,
		input addr,
		input wdata,
		input io,
		input write,
		input m1
	);

endinterface

// File: logic/zx81_pkg.sv
/*
 ZX81 port logic shared definitions
 Bus address views, memory size and joystick layout codes,
 port addresses and fixed read bytes
*/
package zx81_pkg;

	// ========================================
	// Bus address views
	// ========================================

	// Memory view of the address bus
	typedef struct packed {
		logic [1:0]  bank;   // 16K bank number on A15 and A14
		logic [13:0] offset; // Offset inside the bank
	} zx_mem_addr_t;

	// I/O view of the address bus
	typedef struct packed {
		logic [7:0] row;  // Active low keyboard row selects on A15 to A8
		logic [7:0] port; // Port select on A7 to A0
	} zx_io_addr_t;

	typedef union packed {
		zx_mem_addr_t mem;
		zx_io_addr_t  io;
	} zx_addr_t;

	// ========================================
	// Hardware settings
	// ========================================

	typedef logic [1:0] mem_size_t;
	localparam mem_size_t MEM_1K  = 2'd0;
	localparam mem_size_t MEM_16K = 2'd1;
	localparam mem_size_t MEM_32K = 2'd2;
	localparam mem_size_t MEM_48K = 2'd3;

	typedef logic [1:0] joy_layout_t;
	localparam joy_layout_t JOY_CURSOR   = 2'd0; // Keys 5 6 7 8 0
	localparam joy_layout_t JOY_SINCLAIR = 2'd1; // Keys 6 7 8 9 0
	localparam joy_layout_t JOY_ZX81     = 2'd2;
	localparam joy_layout_t JOY_BOTH     = 2'd3; // Sinclair and ZX81 together

	// ========================================
	// Ports and read values
	// ========================================

	localparam logic [15:0] ZXPAND_PORT = 16'hE007;
	localparam logic [15:0] CHROMA_PORT = 16'h7FEF;

	localparam logic [7:0] IDLE_BYTE   = 8'hFF; // Floating bus
	localparam logic [7:0] CHROMA_READ = 8'hDF; // Chroma81 presence byte

endpackage
